/* Bender.yml */
package:
  name: icache

sources:
  # Design sources in compile order
  - logic/icache_pkg.sv
  - logic/inst_cache_memory.sv
  - logic/icache_refill.sv
  - logic/icache_lookup.sv
  - logic/icache_top.sv

  # Verification sources, top module icache_tb
  - target: test
    files:
      - tb/icache_asserts.sv
      - tb/icache_tb.sv

/* compile.f */
logic/icache_pkg.sv
logic/inst_cache_memory.sv
logic/icache_refill.sv
logic/icache_lookup.sv
logic/icache_top.sv
tb/icache_asserts.sv
tb/icache_tb.sv

/* logic/icache_lookup.sv */
// Instruction cache lookup unit
// Accepts fetch addresses, checks tags and valid bits one cycle later and
// returns the selected word on a hit. A miss stalls fetches, asks the refill
// unit for the line and replays the read once the line is written
`timescale 1ns/1ps

module icache_lookup (
  input  logic                           clka,
  input  logic                           rst,
  input  logic                           fetch_valid,
  input  icache_pkg::fetch_addr_t        fetch_addr,
  output logic                           fetch_ready, // Low while a miss is open
  output logic                           inst_valid,  // One pulse per accepted fetch
  output logic [icache_pkg::word_w-1:0]  inst_word,
  output logic [icache_pkg::index_w-1:0] rd_index,    // Read address of the data array
  input  logic [icache_pkg::line_w-1:0]  rd_line,     // Array data, one cycle later
  output logic                           refill_req,  // Miss pulse to refill unit
  output icache_pkg::line_addr_t         refill_line,
  input  logic                           fill_done,   // Line written this cycle
  input  icache_pkg::fill_t              fill
);

  import icache_pkg::*;

  lookup_state_e state_q;
  fetch_addr_t   stage_q;       // Fetch accepted on the last edge, or the one missing
  logic          stage_valid_q; // stage_q holds a fetch still owed a result

  // Stored tag and valid bit of every line
  logic [tag_w-1:0]       tag_q [cache_depth];
  logic [cache_depth-1:0] valid_q;

  logic tag_match; // Stored line belongs to the staged address
  logic run_hit;   // Staged fetch is served this cycle
  logic run_miss;  // Staged fetch needs a refill
  logic accept;    // New fetch taken on the coming edge

  // Data line seen as an array of instructions
  logic [line_words-1:0][word_w-1:0] line_v;

  assign tag_match = valid_q[stage_q.index] && (tag_q[stage_q.index] == stage_q.tag);

  assign run_hit  = (state_q == run) && stage_valid_q && tag_match;
  assign run_miss = (state_q == run) && stage_valid_q && !tag_match;

  // Ready drops already in the cycle the miss shows up
  assign fetch_ready = (state_q == run) && !run_miss;
  assign accept      = fetch_valid && fetch_ready;

  // The array is read with the incoming address so the line arrives together
  // with the staged fetch. During a fill the written index is read instead and
  // the array bypass returns the new line in the replay cycle
  assign rd_index = fill_done ? fill.index : fetch_addr.index;

  assign line_v     = rd_line;
  assign inst_word  = line_v[stage_q.word_sel]; // Same word select for hit and replay
  assign inst_valid = run_hit || (state_q == replay);

  assign refill_req  = run_miss; // Lasts one cycle as the state leaves run at the edge
  assign refill_line = '{tag: stage_q.tag, index: stage_q.index};

  // Lookup FSM
  always_ff @(posedge clka) begin
    if (rst) begin
      state_q <= run;
    end else begin
      case (state_q)
        run: begin
          if (run_miss) begin
            state_q <= miss_wait;
          end
        end
        miss_wait: begin
          if (fill_done) begin
            state_q <= replay; // Line and tag are in place after this edge
          end
        end
        replay:  state_q <= run; // Word is delivered in this cycle
        default: state_q <= run;
      endcase
    end
  end

  // Stage occupancy
  always_ff @(posedge clka) begin
    if (rst) begin
      stage_valid_q <= 1'b0;
    end else if (accept) begin
      stage_valid_q <= 1'b1; // Also covers a hit and a new fetch in one cycle
    end else if (run_hit || (state_q == replay)) begin
      stage_valid_q <= 1'b0; // Result went out and nothing replaced it
    end
  end

  // Stage address is held through the whole miss for the replay
  always_ff @(posedge clka) begin
    if (accept) begin
      stage_q <= fetch_addr;
    end
  end

  // A valid bit is set once its line has been filled
  always_ff @(posedge clka) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill_done) begin
      valid_q[fill.index] <= 1'b1;
    end
  end

  // Tag update in the same cycle the array takes the data
  // An eviction simply overwrites the old tag
  always_ff @(posedge clka) begin
    if (fill_done) begin
      tag_q[fill.index] <= fill.tag;
    end
  end

endmodule

/* logic/icache_pkg.sv */
// Instruction cache shared definitions
// Holds the cache geometry, the fetch address split, the refill transfer
// record and the state types of the lookup and refill FSMs
package icache_pkg;

  // Geometry of the direct-mapped cache
  localparam int addr_w      = 32; // Width of a fetch address
  localparam int word_w      = 32; // One instruction
  localparam int line_words  = 16; // Instructions held by one line
  localparam int line_w      = line_words * word_w; // 512 bits per line
  localparam int cache_depth = 64; // Number of lines in the array

  // Address split, from the top bit down
  localparam int byte_off_w = 2; // Instructions are word aligned
  localparam int word_sel_w = $clog2(line_words); // Picks the word inside a line
  localparam int index_w    = $clog2(cache_depth); // Picks the line
  localparam int tag_w      = addr_w - index_w - word_sel_w - byte_off_w; // 20 bits remain

  // A fetch address as seen by the cache
  typedef struct packed {
    logic [tag_w-1:0]      tag;      // Compared against the stored tag
    logic [index_w-1:0]    index;    // Line in the data and tag arrays
    logic [word_sel_w-1:0] word_sel; // Word returned from the line
    logic [byte_off_w-1:0] byte_off; // Ignored by the cache
  } fetch_addr_t;

  // Names one cache line, which is also the unit of a memory request
  typedef struct packed {
    logic [tag_w-1:0]   tag;
    logic [index_w-1:0] index;
  } line_addr_t;

  // One refill write
  // The same record updates the data array and the tag array
  typedef struct packed {
    logic [index_w-1:0] index; // Line being replaced
    logic [tag_w-1:0]   tag;   // Tag of the incoming line
    logic [line_w-1:0]  data;  // Line as returned by memory
  } fill_t;

  // Lookup FSM
  typedef enum logic [1:0] {
    run,       // Hits served, new fetches accepted
    miss_wait, // Waiting for the refill unit to return the line
    replay     // Reading the freshly written line
  } lookup_state_e;

  // Refill FSM
  typedef enum logic {
    ref_idle, // No request outstanding
    ref_wait  // Memory request issued, waiting for the line
  } refill_state_e;

endpackage

/* logic/icache_refill.sv */
// Instruction cache refill unit
// Turns a miss from the lookup unit into one memory line request and
// hands the returned line to the data array and the tag array
`timescale 1ns/1ps

module icache_refill (
  input  logic                          clka,
  input  logic                          rst,
  input  logic                          refill_req,  // Miss pulse from lookup
  input  icache_pkg::line_addr_t        refill_line, // Line that missed
  output logic                          mem_req,     // One-cycle request to memory
  output icache_pkg::line_addr_t        mem_addr,    // Line requested from memory
  input  logic                          mem_rvalid,  // Line is on mem_rdata
  input  logic [icache_pkg::line_w-1:0] mem_rdata,
  output logic                          fill_done,   // Write strobe for array and tags
  output icache_pkg::fill_t             fill
);

  import icache_pkg::*;

  refill_state_e state_q;  // Refill FSM
  line_addr_t    line_q;   // Line being fetched
  logic          mem_req_q; // Request pulse, one cycle after refill_req
  logic          start;    // A new miss is taken

  // Lookup only raises a miss while no refill is open
  // Checking the state keeps a stray pulse from restarting the refill
  assign start = (state_q == ref_idle) && refill_req;

  always_ff @(posedge clka) begin
    if (rst) begin
      state_q   <= ref_idle;
      mem_req_q <= 1'b0;
    end else begin
      mem_req_q <= start; // A single pulse per miss
      case (state_q)
        ref_idle: begin
          if (start) begin
            state_q <= ref_wait;
          end
        end
        ref_wait: begin
          if (mem_rvalid) begin
            state_q <= ref_idle; // Line is written this cycle and the refill ends
          end
        end
        default: state_q <= ref_idle;
      endcase
    end
  end

  // Line of the miss being served
  always_ff @(posedge clka) begin
    if (start) begin
      line_q <= refill_line;
    end
  end

  assign mem_req  = mem_req_q;
  assign mem_addr = line_q; // Held stable for the whole refill

  // The returned line goes straight to the array without a register stage
  // so lookup can read it back through the bypass on the next cycle
  assign fill_done = (state_q == ref_wait) && mem_rvalid;

  assign fill = '{
    index: line_q.index,
    tag:   line_q.tag,
    data:  mem_rdata
  };

endmodule

/* logic/icache_top.sv */
// Direct-mapped instruction cache
// Joins the lookup unit, the line data array and the refill unit and
// exposes the core fetch port and the memory line port
`timescale 1ns/1ps

module icache_top (
  input  logic                          clka,
  input  logic                          rst,
  input  logic                          fetch_valid,
  input  icache_pkg::fetch_addr_t       fetch_addr,
  output logic                          fetch_ready,
  output logic                          inst_valid,
  output logic [icache_pkg::word_w-1:0] inst_word,
  output logic                          mem_req,
  output icache_pkg::line_addr_t        mem_addr,
  input  logic                          mem_rvalid,
  input  logic [icache_pkg::line_w-1:0] mem_rdata
);

  import icache_pkg::*;

  logic               refill_req;  // Miss from lookup to refill
  line_addr_t         refill_line;
  logic               fill_done;   // Array write enable and tag update strobe
  fill_t              fill;        // Line, index and tag of the write
  logic [index_w-1:0] rd_index;    // Lookup read address
  logic [line_w-1:0]  rd_line;     // Line read back from the array

  icache_lookup lookup_i (
    .clka        (clka),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .inst_valid  (inst_valid),
    .inst_word   (inst_word),
    .rd_index    (rd_index),
    .rd_line     (rd_line),
    .refill_req  (refill_req),
    .refill_line (refill_line),
    .fill_done   (fill_done),
    .fill        (fill)
  );

  // Write comes from the refill unit, read from the lookup unit
  inst_cache_memory data_i (
    .clka  (clka),
    .addra (fill.index),
    .addrb (rd_index),
    .dina  (fill.data),
    .wea   (fill_done),
    .doutb (rd_line)
  );

  icache_refill refill_i (
    .clka        (clka),
    .rst         (rst),
    .refill_req  (refill_req),
    .refill_line (refill_line),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .fill_done   (fill_done),
    .fill        (fill)
  );

endmodule

/* logic/inst_cache_memory.sv */
// Cache line data array
// One write port and one registered read port on a single clock
// A read of the address written in the same cycle returns the new data
`timescale 1ns/1ps

module inst_cache_memory #(
  parameter int ram_width = icache_pkg::line_w,     // Bits per entry
  parameter int ram_depth = icache_pkg::cache_depth // Number of entries
) (
  input  logic                         clka,
  input  logic [$clog2(ram_depth)-1:0] addra, // Write address
  input  logic [$clog2(ram_depth)-1:0] addrb, // Read address
  input  logic [ram_width-1:0]         dina,  // Write data
  input  logic                         wea,   // Write enable
  output logic [ram_width-1:0]         doutb  // Read data, one cycle after addrb
);

  // One line per cache index
  logic [ram_width-1:0] mem [ram_depth];

  logic [ram_width-1:0] rd_data_q; // Entry read from the array
  logic [ram_width-1:0] wr_data_q; // Copy of the last written line
  logic                 bypass_q;  // Last cycle wrote the address that was read

  // Write port
  always_ff @(posedge clka) begin
    if (wea) begin
      mem[addra] <= dina; // Lands at the end of the write cycle
    end
  end

  // Read port returns the old contents when both ports hit one entry
  always_ff @(posedge clka) begin
    rd_data_q <= mem[addrb];
  end

  // Keep what was written so it can stand in for the stale read
  always_ff @(posedge clka) begin
    if (wea) begin
      wr_data_q <= dina;
    end
  end

  // Remember a write and a read to the same entry in one cycle
  always_ff @(posedge clka) begin
    bypass_q <= wea && (addra == addrb);
  end

  // Write-first behaviour on the read port
  assign doutb = bypass_q ? wr_data_q : rd_data_q;

endmodule

/* tb/icache_asserts.sv */
// Bound checker for the instruction cache
// Pairs every accepted fetch with its result, keeps its own record of the
// lines that memory has delivered and checks instruction values, the miss
// protocol toward memory and the state right after reset
`timescale 1ns/1ps

module icache_asserts (
  input logic                               clka,
  input logic                               rst,
  input logic                               fetch_valid,
  input icache_pkg::fetch_addr_t            fetch_addr,
  input logic                               fetch_ready,
  input logic                               inst_valid,
  input logic [icache_pkg::word_w-1:0]      inst_word,
  input logic                               mem_req,
  input icache_pkg::line_addr_t             mem_addr,
  input logic                               mem_rvalid,
  input logic                               refill_req,
  input logic                               fill_done,
  input icache_pkg::lookup_state_e          lookup_state,
  input icache_pkg::refill_state_e          refill_state,
  input logic [icache_pkg::cache_depth-1:0] tag_valid
);

  import icache_pkg::*;

  localparam int fifo_depth = 4; // Never more than one fetch waits for its result
  localparam logic [word_w-1:0] mem_offset = 32'h1000_0000; // Added to each word address

  int fail_count; // Number of failed assertions
  int pending;    // Accepted fetches still owed a result

  logic [addr_w-1:0]             fifo [fifo_depth]; // Accepted addresses in fetch order
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;

  logic                   fetch_seen; // First fetch has been accepted
  logic                   mem_busy;   // A memory request waits for its line
  logic                   miss_open;  // A fetch that missed still waits for its result
  line_addr_t             miss_line;  // Line of the last fetch that should miss
  logic [tag_w-1:0]       res_tag [cache_depth];
  logic [cache_depth-1:0] res_valid;  // Lines delivered since reset

  logic              accept;   // Fetch taken on this edge
  logic              pred_hit; // Taken fetch finds its line resident
  logic              pop;      // Result consumes the oldest fetch
  logic [word_w-1:0] exp_word; // Word memory holds at the oldest address

  assign accept   = fetch_valid && fetch_ready;
  assign pred_hit = res_valid[fetch_addr.index] && (res_tag[fetch_addr.index] == fetch_addr.tag);
  assign pop      = inst_valid && (pending != 0);
  assign exp_word = {fifo[rd_ptr][addr_w-1:2], 2'b00} + mem_offset;

  // Queue of accepted fetch addresses
  always_ff @(posedge clka) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      pending    <= 0;
      fetch_seen <= 1'b0;
    end else begin
      if (accept) begin
        fifo[wr_ptr] <= fetch_addr;
        wr_ptr       <= wr_ptr + 1'b1;
        fetch_seen   <= 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      pending <= pending + int'(accept) - int'(pop);
    end
  end

  // Outstanding memory request and the set of delivered lines
  always_ff @(posedge clka) begin
    if (rst) begin
      mem_busy  <= 1'b0;
      res_valid <= '0;
    end else begin
      if (mem_req) begin
        mem_busy <= 1'b1;
      end
      if (mem_rvalid) begin
        mem_busy                   <= 1'b0;
        res_valid[miss_line.index] <= 1'b1; // Same index of a new tag replaces the old line
      end
    end
  end

  always_ff @(posedge clka) begin
    if (accept && !pred_hit) begin
      miss_line <= '{tag: fetch_addr.tag, index: fetch_addr.index};
    end
    if (mem_rvalid) begin
      res_tag[miss_line.index] <= miss_line.tag;
    end
  end

  // Open from the edge that takes a missing fetch until its result is out
  always_ff @(posedge clka) begin
    if (rst) begin
      miss_open <= 1'b0;
    end else if (accept && !pred_hit) begin
      miss_open <= 1'b1;
    end else if (pop) begin
      miss_open <= 1'b0;
    end
  end

  // Reset leaves every strobe low, the FSMs idle and no line valid
  assert property (@(posedge clka) $fell(rst) |-> !inst_valid && !mem_req && !refill_req &&
                   !fill_done && fetch_ready && (tag_valid == '0) &&
                   (lookup_state == run) && (refill_state == ref_idle))
    else begin
      $error("Cache is not in its reset state after reset was released");
      fail_count++;
    end

  // Nothing moves before the first fetch
  assert property (@(posedge clka) disable iff (rst)
                   !fetch_seen |-> !inst_valid && !mem_req && !refill_req && fetch_ready)
    else begin
      $error("Cache became active before the first fetch was accepted");
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst) inst_valid |-> pending != 0)
    else begin
      $error("inst_valid pulsed with no accepted fetch waiting for a result");
      fail_count++;
    end

  // Results follow fetch order and carry the word memory holds at that address
  assert property (@(posedge clka) disable iff (rst) pop |-> inst_word == exp_word)
    else begin
      $error("error %0t inst_word got %h expected %h", $time, $sampled(inst_word),
             $sampled(exp_word));
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst)
                   accept && pred_hit |=> inst_valid && !refill_req)
    else begin
      $error("A fetch to a resident line was not returned one cycle after acceptance");
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst)
                   accept && !pred_hit |=> refill_req && !inst_valid)
    else begin
      $error("A fetch to a missing line did not raise a refill request");
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst) refill_req |=> mem_req)
    else begin
      $error("mem_req did not follow the refill request by one cycle");
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst) mem_req |-> $past(refill_req))
    else begin
      $error("mem_req pulsed without a preceding miss");
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst) mem_req |-> mem_addr == miss_line)
    else begin
      $error("error %0t mem_addr got %h expected %h", $time, $sampled(mem_addr),
             $sampled(miss_line));
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst) mem_req |-> !mem_busy)
    else begin
      $error("A second memory request was issued while one was outstanding");
      fail_count++;
    end

  // Fetches stall for the whole miss and only then
  assert property (@(posedge clka) disable iff (rst) fetch_ready == !miss_open)
    else begin
      $error("error %0t fetch_ready got %b expected %b", $time, $sampled(fetch_ready),
             $sampled(!miss_open));
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst) mem_rvalid |-> fill_done)
    else begin
      $error("Returned memory line was not written into the cache");
      fail_count++;
    end

  assert property (@(posedge clka) disable iff (rst) mem_rvalid |=> inst_valid)
    else begin
      $error("Replayed fetch was not returned one cycle after the memory line");
      fail_count++;
    end

endmodule

bind icache_top icache_asserts asserts_i (
  .clka         (clka),
  .rst          (rst),
  .fetch_valid  (fetch_valid),
  .fetch_addr   (fetch_addr),
  .fetch_ready  (fetch_ready),
  .inst_valid   (inst_valid),
  .inst_word    (inst_word),
  .mem_req      (mem_req),
  .mem_addr     (mem_addr),
  .mem_rvalid   (mem_rvalid),
  .refill_req   (refill_req),
  .fill_done    (fill_done),
  .lookup_state (lookup_i.state_q),
  .refill_state (refill_i.state_q),
  .tag_valid    (lookup_i.valid_q)
);

/* tb/icache_tb.sv */
// Instruction cache testbench
// Drives directed and random fetches into the cache and models the line
// memory with a random latency of 1 to 8 cycles
// Values and protocol are checked by the bound assertion module
`timescale 1ns/1ps

module icache_tb;

  import icache_pkg::*;

  localparam int n_directed      = 14;
  localparam int n_random        = 24;
  localparam int n_fetch         = n_directed + n_random;
  localparam int watchdog_cycles = n_fetch * 20 + 200; // Worst miss is well under 20 cycles
  localparam logic [addr_w-1:0] mem_offset = 32'h1000_0000;

  // Cold miss, hits on that line, a miss with a fetch queued behind it,
  // then an eviction at index 4 and misses on both tags that share it
  localparam logic [addr_w-1:0] directed_addr [n_directed] = '{
    32'h0000_0104, 32'h0000_0100, 32'h0000_0108, 32'h0000_013C,
    32'h0000_0104, 32'h0000_2000, 32'h0000_2004, 32'h0000_3040,
    32'h0000_2008, 32'h0000_5104, 32'h0000_0108, 32'h0000_5100,
    32'h0000_5110, 32'h0000_5114
  };

  logic              clka;
  logic              rst;
  logic              fetch_valid;
  fetch_addr_t       fetch_addr;
  logic              fetch_ready;
  logic              inst_valid;
  logic [word_w-1:0] inst_word;
  logic              mem_req;
  line_addr_t        mem_addr;
  logic              mem_rvalid;
  logic [line_w-1:0] mem_rdata;

  icache_top dut_i (
    .clka        (clka),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .inst_valid  (inst_valid),
    .inst_word   (inst_word),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata)
  );

  always #5 clka = ~clka; // 10 ns period

  // Each word of a line is its own byte address plus a fixed offset
  function automatic logic [line_w-1:0] line_contents(input line_addr_t line);
    logic [line_w-1:0] data;
    logic [addr_w-1:0] byte_addr;
    for (int w = 0; w < line_words; w++) begin
      byte_addr = {line, word_sel_w'(w), 2'b00};
      data[w*word_w +: word_w] = byte_addr + mem_offset;
    end
    return data;
  endfunction

  task automatic next_cycle();
    @(posedge clka);
    #1; // Inputs change just after the edge
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // Holds the fetch until the cache takes it
  task automatic issue_fetch(input logic [addr_w-1:0] addr);
    fetch_valid = 1'b1;
    fetch_addr  = fetch_addr_t'(addr);
    @(negedge clka); // fetch_ready is settled mid cycle
    while (!fetch_ready) begin
      @(negedge clka);
    end
    next_cycle(); // Accepted on this edge
    fetch_valid = 1'b0;
    fetch_addr  = '0;
  endtask

  // Line memory that serves one request at a time
  task automatic serve_memory();
    line_addr_t line;
    int         latency;
    forever begin
      @(negedge clka);
      if (mem_req) begin
        line    = mem_addr;
        latency = $urandom_range(1, 8);
        repeat (latency) @(posedge clka);
        #1;
        mem_rvalid = 1'b1;
        mem_rdata  = line_contents(line);
        next_cycle();
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
      end
    end
  endtask

  initial begin : stimulus
    logic [addr_w-1:0] addr;
    void'($urandom(54));
    clka        = 1'b0;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    fork
      serve_memory(); // Memory model runs beside the fetch stimulus
    join_none
    repeat (2) @(posedge clka);
    #1;
    rst = 1'b0;
    idle_cycles(4); // Quiet period checked before the first fetch

    for (int i = 0; i < n_directed; i++) begin
      issue_fetch(directed_addr[i]); // No gaps, so hits run back to back
    end

    // Three tags over four indexes give hits, misses and evictions
    for (int i = 0; i < n_random; i++) begin
      addr = ($urandom_range(0, 2) << 12) | ($urandom_range(0, 3) << 6) |
             ($urandom_range(0, 15) << 2);
      issue_fetch(addr);
      idle_cycles($urandom_range(0, 2));
    end

    wait (dut_i.asserts_i.pending == 0); // Last result has come back
    idle_cycles(4);
    if (dut_i.asserts_i.fail_count != 0) begin
      $display("SIMULATION FAILED");
      $fatal(1, "Cache checks reported errors");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

  // Stops the run at the first failed assertion
  initial begin : failure_monitor
    wait (dut_i.asserts_i.fail_count != 0);
    $display("SIMULATION FAILED");
    $fatal(1, "A cache check failed, see the error above");
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clka);
    $display("Timeout, the cache did not return all results in time");
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule
